// File: temp_sensor_ctrl.f
src/temp_sensor_pkg.sv
src/retry_limiter.sv
src/sensor_phase_ctrl.sv
src/i2c_txn_sequencer.sv
src/temp_sensor_ctrl.sv
tests/i2c_master_model.sv
tests/tb_temp_sensor_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_temp_sensor_ctrl
FILELIST  ?= temp_sensor_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard src/*.sv) $(wildcard tests/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_temp_sensor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_temp_sensor_ctrl import temp_sensor_pkg::*; ();

  localparam int TXN_CYCLES = 50;

  typedef struct packed {
    logic      rst;
    logic      err_end;
    logic      nak;
    byte_t     rd;
    int        gap;
    txn_kind_e kind;
    byte_t     ptr;
    logic      push;
    logic      frac;
  } row_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic start, addr_valid, addr_ready, wr_valid, wr_ready, nbytes_valid, nbytes_ready;
  logic rd_valid, rd_ready, nak, sample_valid, sample_ready, err;
  byte_t addr_bits, wr_bits, nbytes_bits, rd_bits;
  sample_t sample;
  logic nak_en = 1'b0;
  byte_t rd_byte = '0;
  int gap = 0;
  byte_t cap_addr, cap_ptr, cap_data, cap_nbytes;
  logic [1:0] wr_cnt;
  logic rd_seen, push_seen;
  sample_t cap_sample;

  row_t  rows[$];
  string names[$];
  logic  next_rst = 1'b0;
  int    n_pass = 0;
  int    n_fail = 0;
  int    wd_cycles = 0;

  always #5 clk = ~clk;

  temp_sensor_ctrl DUT (
    .i_clk(clk), .i_rst(rst), .o_start(start),
    .o_addr_bits(addr_bits), .o_addr_valid(addr_valid), .i_addr_ready(addr_ready),
    .o_wr_bits(wr_bits), .o_wr_valid(wr_valid), .i_wr_ready(wr_ready),
    .o_nbytes_bits(nbytes_bits), .o_nbytes_valid(nbytes_valid),
    .i_nbytes_ready(nbytes_ready),
    .i_rd_bits(rd_bits), .i_rd_valid(rd_valid), .o_rd_ready(rd_ready), .i_nak(nak),
    .o_sample(sample), .o_sample_valid(sample_valid), .i_sample_ready(sample_ready),
    .o_err(err)
  );

  i2c_master_model u_master (
    .i_clk(clk), .i_rst(rst), .i_start(start),
    .i_addr_bits(addr_bits), .i_addr_valid(addr_valid), .o_addr_ready(addr_ready),
    .i_wr_bits(wr_bits), .i_wr_valid(wr_valid), .o_wr_ready(wr_ready),
    .i_nbytes_bits(nbytes_bits), .i_nbytes_valid(nbytes_valid),
    .o_nbytes_ready(nbytes_ready),
    .o_rd_bits(rd_bits), .o_rd_valid(rd_valid), .i_rd_ready(rd_ready), .o_nak(nak),
    .i_sample(sample), .i_sample_valid(sample_valid), .o_sample_ready(sample_ready),
    .i_nak_en(nak_en), .i_rd_byte(rd_byte), .i_gap(gap),
    .o_cap_addr(cap_addr), .o_cap_ptr(cap_ptr), .o_cap_data(cap_data),
    .o_cap_nbytes(cap_nbytes), .o_wr_cnt(wr_cnt), .o_rd_seen(rd_seen),
    .o_push_seen(push_seen), .o_cap_sample(cap_sample)
  );

  task automatic check_byte(string name, byte_t exp, byte_t act);
    if (exp === act) begin
      n_pass++;
      $display("ok  %s = %0d", name, act);
    end else begin
      n_fail++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_sample(string name, sample_t exp, sample_t act);
    if (exp === act) begin
      n_pass++;
      $display("ok  %s = frac %0b data %0d", name, act.frac, act.data);
    end else begin
      n_fail++;
      $display("ERR %s expected frac %0b data %0d actual frac %0b data %0d",
               name, exp.frac, exp.data, act.frac, act.data);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp === act) begin
      n_pass++;
      $display("ok  %s = %0b", name, act);
    end else begin
      n_fail++;
      $display("ERR %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  task automatic add_txn(string name, txn_kind_e kind, byte_t ptr, byte_t rd, int gp,
                         logic push, logic frac);
    row_t r;
    r = '{rst: next_rst, err_end: 1'b0, nak: 1'b0, rd: rd, gap: gp, kind: kind,
          ptr: ptr, push: push, frac: frac};
    rows.push_back(r);
    names.push_back(name);
    next_rst = 1'b0;
  endtask

  task automatic add_nak(string name, txn_kind_e kind, byte_t ptr);
    add_txn(name, kind, ptr, 8'd0, 0, 1'b0, 1'b0);
    rows[rows.size()-1].nak = 1'b1;
  endtask

  task automatic add_err_stop(string name);
    add_txn(name, READ_REG, REG_TEMP, 8'd0, 0, 1'b0, 1'b0);
    rows[rows.size()-1].err_end = 1'b1;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("reset_idle", 1'b0, start | addr_valid | wr_valid | nbytes_valid |
              rd_ready | sample_valid | err);
  endtask

  task automatic wait_err_stop(string name);
    int starts;
    int waited;
    starts = 0;
    waited = 0;
    while (!err && (waited < TXN_CYCLES)) begin
      @(negedge clk);
      waited++;
    end
    check_bit({name, "_err"}, 1'b1, err);
    repeat (20) begin
      @(negedge clk);
      if (start || addr_valid) starts++;
    end
    check_bit({name, "_no_start"}, 1'b0, starts != 0);
  endtask

  function automatic logic row_done(row_t r);
    if (r.nak) return nak;
    if (r.kind == WRITE_REG) return wr_cnt == 2'd2;
    return r.push ? push_seen : rd_seen;
  endfunction

  task automatic run_row(row_t r, string name);
    logic    unstable;
    logic    seen;
    sample_t held;
    sample_t exp_s;
    int      pushes;  // FIFO handshakes since the previous row
    unstable = 1'b0;
    seen = 1'b0;
    held = '0;
    pushes = 0;
    @(posedge clk);
    nak_en  <= r.nak;
    rd_byte <= r.rd;
    gap     <= r.gap;
    do begin
      @(negedge clk);
      if (sample_valid && sample_ready) pushes++;
    end while (!start);
    do begin
      @(negedge clk);
      if (sample_valid) begin
        if (seen && sample != held) unstable = 1'b1;
        held = sample;
        seen = 1'b1;
      end
      if (sample_valid && sample_ready) pushes++;
    end while (!row_done(r));
    check_byte({name, "_addr"}, (r.kind == WRITE_REG) ? SENSOR_ADDR_WR : SENSOR_ADDR_RD,
               cap_addr);
    if (!r.nak) begin
      check_byte({name, "_ptr"}, r.ptr, cap_ptr);
      if (r.kind == WRITE_REG) check_byte({name, "_data"}, CONFIG_VALUE, cap_data);
      else check_byte({name, "_nbytes"}, 8'd0, cap_nbytes);
    end
    check_byte({name, "_pushes"}, byte_t'(r.push), byte_t'(pushes));
    if (r.push) begin
      exp_s.frac = r.frac;
      exp_s.data = r.rd;
      check_sample({name, "_sample"}, exp_s, cap_sample);
      check_bit({name, "_unstable"}, 1'b0, unstable);
    end
  endtask

  initial begin
    void'($urandom(32'hfab1bbe3));
    // Normal path, READING under random FIFO stalls
    next_rst = 1'b1;
    add_txn("probe", READ_REG, REG_TEMP, 8'h19, 0, 1'b0, 1'b0);
    add_txn("cfg_wr", WRITE_REG, REG_CONFIG, 8'd0, 0, 1'b0, 1'b0);
    add_txn("cfg_rd", READ_REG, REG_CONFIG, CONFIG_VALUE, 0, 1'b0, 1'b0);
    for (int i = 0; i < 8; i++)
      add_txn($sformatf("read_%0d", i), READ_REG, i[0] ? REG_TEMP_FRAC : REG_TEMP,
              byte_t'($urandom), int'($urandom % 8), 1'b1, i[0]);
    // Nine NAKs recover, ten stick
    next_rst = 1'b1;
    for (int i = 0; i < 9; i++) add_nak($sformatf("probe_nak_%0d", i), READ_REG, REG_TEMP);
    add_txn("probe_retry", READ_REG, REG_TEMP, 8'h1a, 0, 1'b0, 1'b0);
    add_txn("nak_cfg_wr", WRITE_REG, REG_CONFIG, 8'd0, 0, 1'b0, 1'b0);
    add_txn("nak_cfg_rd", READ_REG, REG_CONFIG, CONFIG_VALUE, 0, 1'b0, 1'b0);
    add_txn("nak_read", READ_REG, REG_TEMP, 8'h33, 0, 1'b1, 1'b0);
    for (int i = 0; i < 10; i++) add_nak($sformatf("frac_nak_%0d", i), READ_REG, REG_TEMP_FRAC);
    add_err_stop("nak_limit");
    // Nine bad read-backs, then a match
    for (int n = 9; n <= 10; n++) begin
      next_rst = 1'b1;
      add_txn($sformatf("mis%0d_probe", n), READ_REG, REG_TEMP, 8'h15, 0, 1'b0, 1'b0);
      for (int i = 0; i < n; i++) begin
        add_txn($sformatf("mis%0d_wr_%0d", n, i), WRITE_REG, REG_CONFIG, 8'd0, 0, 1'b0, 1'b0);
        add_txn($sformatf("mis%0d_rd_%0d", n, i), READ_REG, REG_CONFIG,
                byte_t'(8'h40 + i), 0, 1'b0, 1'b0);
      end
      if (n == 9) begin
        // Match closes the nine-mismatch group
        add_txn("mis9_wr_ok", WRITE_REG, REG_CONFIG, 8'd0, 0, 1'b0, 1'b0);
        add_txn("mis9_rd_ok", READ_REG, REG_CONFIG, CONFIG_VALUE, 0, 1'b0, 1'b0);
        add_txn("mis9_read", READ_REG, REG_TEMP, 8'h21, 2, 1'b1, 1'b0);
      end
    end
    add_err_stop("mis_limit");
    wd_cycles = rows.size() * TXN_CYCLES;

    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].rst) apply_reset();
      if (rows[i].err_end) wait_err_stop(names[i]);
      else run_row(rows[i], names[i]);
    end

    $display("%0d checks passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles + 100) @(posedge clk);
    $display("watchdog expired, a transaction never completed");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/i2c_master_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_model import temp_sensor_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_start,
  input  byte_t   i_addr_bits,
  input  logic    i_addr_valid,
  output logic    o_addr_ready,
  input  byte_t   i_wr_bits,
  input  logic    i_wr_valid,
  output logic    o_wr_ready,
  input  byte_t   i_nbytes_bits,
  input  logic    i_nbytes_valid,
  output logic    o_nbytes_ready,
  output byte_t   o_rd_bits,
  output logic    o_rd_valid,
  input  logic    i_rd_ready,
  output logic    o_nak,
  input  sample_t i_sample,
  input  logic    i_sample_valid,
  output logic    o_sample_ready,
  input  logic    i_nak_en,       // Script for the current transaction
  input  byte_t   i_rd_byte,
  input  int      i_gap,
  output byte_t   o_cap_addr,
  output byte_t   o_cap_ptr,
  output byte_t   o_cap_data,
  output byte_t   o_cap_nbytes,
  output logic [1:0] o_wr_cnt,
  output logic    o_rd_seen,
  output logic    o_push_seen,
  output sample_t o_cap_sample
);

  logic r_ready;
  int   r_gap;  // FIFO stall cycles left

  assign o_addr_ready   = r_ready;
  assign o_wr_ready     = r_ready;
  assign o_nbytes_ready = r_ready;
  assign o_rd_valid     = r_ready;
  assign o_rd_bits      = i_rd_byte;
  assign o_sample_ready = r_ready && (r_gap == 0);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_ready      <= 1'b0;
      r_gap        <= 0;
      o_nak        <= 1'b0;
      o_cap_addr   <= '0;
      o_cap_ptr    <= '0;
      o_cap_data   <= '0;
      o_cap_nbytes <= '0;
      o_wr_cnt     <= '0;
      o_rd_seen    <= 1'b0;
      o_push_seen  <= 1'b0;
      o_cap_sample <= '0;
    end else begin
      r_ready <= 1'b1;
      o_nak   <= i_start && i_nak_en;  // One-cycle NAK right after start
      if (i_start) begin
        o_wr_cnt    <= '0;
        o_rd_seen   <= 1'b0;
        o_push_seen <= 1'b0;
        r_gap       <= i_gap;
      end
      if (i_addr_valid && o_addr_ready) o_cap_addr <= i_addr_bits;
      if (i_wr_valid && o_wr_ready) begin
        if (o_wr_cnt == 2'd0) o_cap_ptr <= i_wr_bits;
        else o_cap_data <= i_wr_bits;
        o_wr_cnt <= o_wr_cnt + 2'd1;
      end
      if (i_nbytes_valid && o_nbytes_ready) o_cap_nbytes <= i_nbytes_bits;
      if (i_rd_ready && o_rd_valid) o_rd_seen <= 1'b1;
      if (i_sample_valid) begin
        if (r_gap != 0) begin
          r_gap <= r_gap - 1;
        end else if (r_ready) begin
          o_push_seen  <= 1'b1;
          o_cap_sample <= i_sample;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/temp_sensor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module temp_sensor_ctrl import temp_sensor_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  output logic    o_start,
  output byte_t   o_addr_bits,
  output logic    o_addr_valid,
  input  logic    i_addr_ready,
  output byte_t   o_wr_bits,
  output logic    o_wr_valid,
  input  logic    i_wr_ready,
  output byte_t   o_nbytes_bits,
  output logic    o_nbytes_valid,
  input  logic    i_nbytes_ready,
  input  byte_t   i_rd_bits,
  input  logic    i_rd_valid,
  output logic    o_rd_ready,
  input  logic    i_nak,
  output sample_t o_sample,
  output logic    o_sample_valid,
  input  logic    i_sample_ready,
  output logic    o_err
);

  txn_req_t req;
  logic     req_frac;
  logic     req_valid;
  logic     req_ready;
  logic     done;
  txn_rsp_t rsp;
  logic     push;
  logic     outcome;
  logic     outcome_nak;
  logic     mismatch;
  logic     phase_adv;

  sensor_phase_ctrl u_phase (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_req       (req),
    .o_req_frac  (req_frac),
    .o_req_valid (req_valid),
    .i_req_ready (req_ready),
    .i_done      (done),
    .i_rsp       (rsp),
    .o_push      (push),
    .o_outcome   (outcome),
    .o_nak       (outcome_nak),
    .o_mismatch  (mismatch),
    .o_phase_adv (phase_adv),
    .i_err       (o_err)
  );

  i2c_txn_sequencer u_seq (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_req          (req),
    .i_req_frac     (req_frac),
    .i_req_valid    (req_valid),
    .o_req_ready    (req_ready),
    .o_done         (done),
    .o_rsp          (rsp),
    .i_push         (push),
    .o_start        (o_start),
    .o_addr_bits    (o_addr_bits),
    .o_addr_valid   (o_addr_valid),
    .i_addr_ready   (i_addr_ready),
    .o_wr_bits      (o_wr_bits),
    .o_wr_valid     (o_wr_valid),
    .i_wr_ready     (i_wr_ready),
    .o_nbytes_bits  (o_nbytes_bits),
    .o_nbytes_valid (o_nbytes_valid),
    .i_nbytes_ready (i_nbytes_ready),
    .i_rd_bits      (i_rd_bits),
    .i_rd_valid     (i_rd_valid),
    .o_rd_ready     (o_rd_ready),
    .i_nak          (i_nak),
    .o_sample       (o_sample),
    .o_sample_valid (o_sample_valid),
    .i_sample_ready (i_sample_ready)
  );

  retry_limiter u_retry (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_outcome   (outcome),
    .i_nak       (outcome_nak),
    .i_mismatch  (mismatch),
    .i_phase_adv (phase_adv),
    .o_err       (o_err)
  );

endmodule

`default_nettype wire

// File: src/i2c_txn_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_txn_sequencer import temp_sensor_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  txn_req_t i_req,
  input  logic     i_req_frac,
  input  logic     i_req_valid,
  output logic     o_req_ready,
  output logic     o_done,
  output txn_rsp_t o_rsp,
  input  logic     i_push,
  output logic     o_start,
  output byte_t    o_addr_bits,
  output logic     o_addr_valid,
  input  logic     i_addr_ready,
  output byte_t    o_wr_bits,
  output logic     o_wr_valid,
  input  logic     i_wr_ready,
  output byte_t    o_nbytes_bits,
  output logic     o_nbytes_valid,
  input  logic     i_nbytes_ready,
  input  byte_t    i_rd_bits,
  input  logic     i_rd_valid,
  output logic     o_rd_ready,
  input  logic     i_nak,
  output sample_t  o_sample,
  output logic     o_sample_valid,
  input  logic     i_sample_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_PTR,
    S_DATA,
    S_NBYTES,
    S_READ,
    S_PUSH,
    S_WAIT
  } step_e;

  step_e    r_step;
  logic     r_start;
  logic     r_done;
  logic     r_nak_prev;
  logic     nak_rise;
  logic     abort;
  logic     finish;
  txn_req_t r_req;
  logic     r_frac;
  logic     r_push;
  txn_rsp_t r_rsp;

  assign nak_rise = i_nak & ~r_nak_prev;
  // Byte already read once in S_PUSH, so a late NAK must not drop it
  assign abort  = nak_rise && (r_step != S_IDLE) && (r_step != S_PUSH);
  assign finish = (r_step == S_WAIT) && i_addr_ready;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_step     <= S_IDLE;
      r_start    <= 1'b0;
      r_done     <= 1'b0;
      r_nak_prev <= 1'b0;
    end else begin
      r_nak_prev <= i_nak;
      r_start    <= 1'b0;
      r_done     <= 1'b0;
      if (abort) begin
        r_step <= S_IDLE;
        r_done <= 1'b1;
      end else begin
        case (r_step)
          S_IDLE: begin
            if (i_req_valid) begin
              r_step  <= S_ADDR;
              r_start <= 1'b1;  // Start goes with first address cycle
            end
          end
          S_ADDR: if (i_addr_ready) r_step <= S_PTR;
          S_PTR: begin
            if (i_wr_ready) begin
              r_step <= (r_req.kind == WRITE_REG) ? S_DATA : S_NBYTES;
            end
          end
          S_DATA: if (i_wr_ready) r_step <= S_WAIT;
          S_NBYTES: if (i_nbytes_ready) r_step <= S_READ;
          S_READ: if (i_rd_valid) r_step <= r_push ? S_PUSH : S_WAIT;
          S_PUSH: if (i_sample_ready) r_step <= S_WAIT;
          S_WAIT: begin
            if (finish) begin
              r_step <= S_IDLE;
              r_done <= 1'b1;
            end
          end
          default: r_step <= S_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_req_ready && i_req_valid) begin
      r_req  <= i_req;
      r_frac <= i_req_frac;
      r_push <= i_push;
    end
    if ((r_step == S_READ) && i_rd_valid) r_rsp.rd_byte <= i_rd_bits;
    if (abort) r_rsp.nak <= 1'b1;
    else if (finish) r_rsp.nak <= 1'b0;
  end

  assign o_req_ready = (r_step == S_IDLE);
  assign o_done      = r_done;
  assign o_rsp       = r_rsp;
  assign o_start     = r_start;

  assign o_addr_bits    = r_req.addr;
  assign o_addr_valid   = (r_step == S_ADDR);
  assign o_wr_bits      = (r_step == S_DATA) ? r_req.data : r_req.ptr;
  assign o_wr_valid     = (r_step == S_PTR) || (r_step == S_DATA);
  assign o_nbytes_bits  = READ_NBYTES;
  assign o_nbytes_valid = (r_step == S_NBYTES);
  assign o_rd_ready     = (r_step == S_READ);

  assign o_sample.frac  = r_frac;
  assign o_sample.data  = r_rsp.rd_byte;
  assign o_sample_valid = (r_step == S_PUSH);

  a_start_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_start |=> !o_start);

  // A NAK edge may end the transaction, otherwise valids wait for ready
  a_addr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_addr_valid && !i_addr_ready && !nak_rise |=> o_addr_valid);
  a_wr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wr_valid && !i_wr_ready && !nak_rise |=> o_wr_valid);
  a_nbytes_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_nbytes_valid && !i_nbytes_ready && !nak_rise |=> o_nbytes_valid);
  a_sample_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_sample_valid && !i_sample_ready |=> o_sample_valid && $stable(o_sample));

endmodule

`default_nettype wire

// File: src/sensor_phase_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_phase_ctrl import temp_sensor_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  output txn_req_t o_req,
  output logic     o_req_frac,
  output logic     o_req_valid,
  input  logic     i_req_ready,
  input  logic     i_done,
  input  txn_rsp_t i_rsp,
  output logic     o_push,
  output logic     o_outcome,
  output logic     o_nak,
  output logic     o_mismatch,
  output logic     o_phase_adv,
  input  logic     i_err
);

  phase_e r_phase;
  logic   r_frac;     // Next READING pointer is the fraction
  logic   r_pending;
  logic   r_busy;
  logic   rd_ok;
  logic   success;

  assign rd_ok   = (i_rsp.rd_byte == CONFIG_VALUE);
  assign success = i_done && !i_rsp.nak;

  assign o_outcome  = i_done;
  assign o_nak      = i_done && i_rsp.nak;
  assign o_mismatch = success && (r_phase == CFG_READ) && !rd_ok;
  // Config write and read-back form one round, so leaving CFG_WRITE is no advance
  assign o_phase_adv = success && ((r_phase == PROBE) || ((r_phase == CFG_READ) && rd_ok));

  // Error from the last outcome lands together with the pending request
  assign o_req_valid = r_pending && !i_err;
  assign o_req_frac  = r_frac;
  assign o_push      = (r_phase == READING);

  always_comb begin
    o_req      = '0;
    o_req.kind = READ_REG;
    o_req.addr = SENSOR_ADDR_RD;
    case (r_phase)
      PROBE: o_req.ptr = REG_TEMP;
      CFG_WRITE: begin
        o_req.kind = WRITE_REG;
        o_req.addr = SENSOR_ADDR_WR;
        o_req.ptr  = REG_CONFIG;
        o_req.data = CONFIG_VALUE;
      end
      CFG_READ: o_req.ptr = REG_CONFIG;
      READING: o_req.ptr = r_frac ? REG_TEMP_FRAC : REG_TEMP;
      default: o_req.ptr = REG_TEMP;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_phase   <= PROBE;
      r_frac    <= 1'b0;
      r_pending <= 1'b0;
      r_busy    <= 1'b0;
    end else if (i_err) begin
      r_phase   <= NO_RESPONSE;
      r_pending <= 1'b0;
    end else if (o_req_valid && i_req_ready) begin
      r_pending <= 1'b0;
      r_busy    <= 1'b1;
    end else if (i_done) begin
      r_busy    <= 1'b0;
      r_pending <= 1'b1;  // NAK reissues the same request
      if (success) begin
        case (r_phase)
          PROBE: r_phase <= CFG_WRITE;
          CFG_WRITE: r_phase <= CFG_READ;
          CFG_READ: r_phase <= rd_ok ? READING : CFG_WRITE;
          READING: r_frac <= ~r_frac;
          default: r_phase <= NO_RESPONSE;
        endcase
      end
    end else if (!r_pending && !r_busy && (r_phase != NO_RESPONSE)) begin
      r_pending <= 1'b1;  // First probe after reset
    end
  end

endmodule

`default_nettype wire

// File: src/retry_limiter.sv
`timescale 1ns/1ps
`default_nettype none

module retry_limiter import temp_sensor_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_outcome,
  input  logic i_nak,
  input  logic i_mismatch,
  input  logic i_phase_adv,
  output logic o_err
);

  logic [RETRY_W-1:0] r_nak_cnt;
  logic [RETRY_W-1:0] r_mis_cnt;
  logic               nak_limit;
  logic               mis_limit;

  // This outcome is the one that reaches the limit
  assign nak_limit = i_outcome && i_nak && (r_nak_cnt == RETRY_W'(MAX_RETRIES - 1));
  assign mis_limit = i_outcome && i_mismatch && (r_mis_cnt == RETRY_W'(MAX_RETRIES - 1));

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_nak_cnt <= '0;
      r_mis_cnt <= '0;
      o_err     <= 1'b0;
    end else begin
      if (i_phase_adv) begin
        r_nak_cnt <= '0;
      end else if (i_outcome) begin
        if (!i_nak) begin
          r_nak_cnt <= '0;
        end else if (r_nak_cnt != RETRY_W'(MAX_RETRIES)) begin
          r_nak_cnt <= r_nak_cnt + 1'b1;  // Saturates at the limit
        end
      end

      // Only a good read-back leaves the config loop
      if (i_phase_adv) begin
        r_mis_cnt <= '0;
      end else if (i_outcome && i_mismatch && (r_mis_cnt != RETRY_W'(MAX_RETRIES))) begin
        r_mis_cnt <= r_mis_cnt + 1'b1;
      end

      if (nak_limit || mis_limit) o_err <= 1'b1;
    end
  end

  a_err_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
    o_err |=> o_err);

endmodule

`default_nettype wire

// File: src/temp_sensor_pkg.sv
`default_nettype none

package temp_sensor_pkg;

  localparam int BYTE_W = 8;

  typedef logic [BYTE_W-1:0] byte_t;

  // Sensor bus address, read and write forms
  localparam byte_t SENSOR_ADDR_RD = 8'd79;
  localparam byte_t SENSOR_ADDR_WR = 8'd78;

  // Register pointers
  localparam byte_t REG_TEMP      = 8'd0;
  localparam byte_t REG_TEMP_FRAC = 8'd15;
  localparam byte_t REG_CONFIG    = 8'd3;

  localparam byte_t CONFIG_VALUE = 8'd4;
  localparam byte_t READ_NBYTES  = 8'd0;  // Count minus one

  localparam int MAX_RETRIES = 10;
  localparam int RETRY_W     = $clog2(MAX_RETRIES + 1);

  typedef enum logic [2:0] {
    PROBE,
    CFG_WRITE,
    CFG_READ,
    READING,
    NO_RESPONSE
  } phase_e;

  // READ_REG writes the pointer, then reads one byte
  typedef enum logic {
    READ_REG,
    WRITE_REG
  } txn_kind_e;

  typedef struct packed {
    txn_kind_e kind;
    byte_t     addr;
    byte_t     ptr;
    byte_t     data;
  } txn_req_t;

  typedef struct packed {
    logic  nak;
    byte_t rd_byte;
  } txn_rsp_t;

  // FIFO word
  typedef struct packed {
    logic  frac;
    byte_t data;
  } sample_t;

endpackage

`default_nettype wire
